//--- hdl/acs_unit.sv
`timescale 1ns/1ps

module acs_unit (
  input  logic                        clk,
  input  logic                        sys_rst,
  input  viterbi_pkg::metric_t        metric_p0_i,
  input  viterbi_pkg::metric_t        metric_p1_i,
  input  viterbi_pkg::branch_metric_t branch_p0_i,
  input  viterbi_pkg::branch_metric_t branch_p1_i,
  input  logic                        update_i,
  output viterbi_pkg::metric_t        metric_o,
  output logic                        decision_o
);
  import viterbi_pkg::*;

  metric_t cand_p0;
  metric_t cand_p1;
  logic    pick_p1;

  assign cand_p0 = metric_p0_i + metric_t'(branch_p0_i);
  assign cand_p1 = metric_p1_i + metric_t'(branch_p1_i);

  // ties keep the even predecessor
  assign pick_p1 = cand_p1 < cand_p0;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      metric_o <= '0;
      decision_o <= 1'b0;
    end else if (update_i) begin
      metric_o <= pick_p1 ? cand_p1 : cand_p0;
      decision_o <= pick_p1;
    end
  end

endmodule

//--- hdl/branch_metric_unit.sv
`timescale 1ns/1ps

module branch_metric_unit (
  input  logic                        clk,
  input  logic                        sys_rst,
  input  viterbi_pkg::soft_t          sym_i_i,
  input  viterbi_pkg::soft_t          sym_q_i,
  input  logic                        pair_valid_i,
  output viterbi_pkg::branch_metric_t metric_00_o,
  output viterbi_pkg::branch_metric_t metric_01_o,
  output viterbi_pkg::branch_metric_t metric_10_o,
  output viterbi_pkg::branch_metric_t metric_11_o,
  output logic                        metric_valid_o
);
  import viterbi_pkg::*;

  // distance of each sample to an expected 0 and an expected 1
  soft_t i_one;
  soft_t q_one;

  assign i_one = SOFT_MAX - sym_i_i;
  assign q_one = SOFT_MAX - sym_q_i;

  // metric_xy is for e1 = x, e0 = y; I goes with e0, Q with e1
  always_ff @(posedge clk) begin
    metric_00_o <= branch_metric_t'(sym_i_i) + branch_metric_t'(sym_q_i);
    metric_01_o <= branch_metric_t'(i_one) + branch_metric_t'(sym_q_i);
    metric_10_o <= branch_metric_t'(sym_i_i) + branch_metric_t'(q_one);
    metric_11_o <= branch_metric_t'(i_one) + branch_metric_t'(q_one);
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      metric_valid_o <= 1'b0;
    end else begin
      metric_valid_o <= pair_valid_i;
    end
  end

endmodule

//--- hdl/metric_normalizer.sv
`timescale 1ns/1ps

module metric_normalizer (
  input  logic                 clk,
  input  logic                 sys_rst,
  input  viterbi_pkg::metric_t metrics_i [viterbi_pkg::NUM_STATES],
  input  logic                 update_i,
  output viterbi_pkg::metric_t normalized_metrics_o [viterbi_pkg::NUM_STATES],
  output logic                 normalized_o
);
  import viterbi_pkg::*;

  logic all_above;

  // every state has to be at half range before anything is subtracted
  always_comb begin
    all_above = 1'b1;
    for (int s = 0; s < NUM_STATES; s++) begin
      if (metrics_i[s] < NORM_THRESHOLD) begin
        all_above = 1'b0;
      end
    end
  end

  always_comb begin
    for (int s = 0; s < NUM_STATES; s++) begin
      if (all_above) begin
        normalized_metrics_o[s] = metrics_i[s] - NORM_THRESHOLD;
      end else begin
        normalized_metrics_o[s] = metrics_i[s];
      end
    end
  end

  // only counts when the ACS array actually takes the values
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      normalized_o <= 1'b0;
    end else begin
      normalized_o <= update_i & all_above;
    end
  end

endmodule

//--- hdl/symbol_pair_collector.sv
`timescale 1ns/1ps

module symbol_pair_collector (
  input  logic                clk,
  input  logic                sys_rst,
  input  viterbi_pkg::soft_t  soft_i,
  input  logic                soft_valid_i,
  output logic                soft_ready_o,
  output viterbi_pkg::soft_t  sym_i_o,
  output viterbi_pkg::soft_t  sym_q_o,
  output logic                pair_valid_o
);
  import viterbi_pkg::*;

  // 0 means the next sample is I
  logic  phase_q;
  soft_t i_hold;
  logic  accept;

  assign accept = soft_valid_i & soft_ready_o;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      soft_ready_o <= 1'b0;
      phase_q <= 1'b0;
      pair_valid_o <= 1'b0;
    end else begin
      soft_ready_o <= 1'b1;
      pair_valid_o <= accept & phase_q;
      if (accept) begin
        phase_q <= ~phase_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && !phase_q) begin
      i_hold <= soft_i;
    end
    // pair goes out together on the Q edge
    if (accept && phase_q) begin
      sym_i_o <= i_hold;
      sym_q_o <= soft_i;
    end
  end

endmodule

//--- hdl/trellis_array.sv
`timescale 1ns/1ps

module trellis_array (
  input  logic                        clk,
  input  logic                        sys_rst,
  input  viterbi_pkg::branch_metric_t metric_00_i,
  input  viterbi_pkg::branch_metric_t metric_01_i,
  input  viterbi_pkg::branch_metric_t metric_10_i,
  input  viterbi_pkg::branch_metric_t metric_11_i,
  input  logic                        metric_valid_i,
  output viterbi_pkg::decision_vec_t  decisions_o,
  output logic                        decision_valid_o,
  output viterbi_pkg::metric_t        state0_metric_o,
  output logic                        normalized_o
);
  import viterbi_pkg::*;

  metric_t        path_metrics [NUM_STATES];
  metric_t        norm_metrics [NUM_STATES];
  branch_metric_t branch [4];

  // indexed by the code word {e1, e0}
  assign branch[0] = metric_00_i;
  assign branch[1] = metric_01_i;
  assign branch[2] = metric_10_i;
  assign branch[3] = metric_11_i;

  metric_normalizer u_metric_normalizer (
    .clk                  (clk),
    .sys_rst              (sys_rst),
    .metrics_i            (path_metrics),
    .update_i             (metric_valid_i),
    .normalized_metrics_o (norm_metrics),
    .normalized_o         (normalized_o)
  );

  for (genvar n = 0; n < NUM_STATES; n++) begin : g_state
    localparam state_t N = state_t'(n);
    // predecessors drop the oldest bit, new input bit enters at the top
    localparam state_t P0 = N << 1;
    localparam state_t P1 = P0 | state_t'(1);
    localparam logic [1:0] CODE_P0 = expected_code(P0, N[$bits(state_t)-1]);
    localparam logic [1:0] CODE_P1 = expected_code(P1, N[$bits(state_t)-1]);

    acs_unit u_acs_unit (
      .clk         (clk),
      .sys_rst     (sys_rst),
      .metric_p0_i (norm_metrics[P0]),
      .metric_p1_i (norm_metrics[P1]),
      .branch_p0_i (branch[CODE_P0]),
      .branch_p1_i (branch[CODE_P1]),
      .update_i    (metric_valid_i),
      .metric_o    (path_metrics[n]),
      .decision_o  (decisions_o[n])
    );
  end

  assign state0_metric_o = path_metrics[0];

  // lines up with the ACS registers
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      decision_valid_o <= 1'b0;
    end else begin
      decision_valid_o <= metric_valid_i;
    end
  end

endmodule

//--- hdl/viterbi_decoder.sv
`timescale 1ns/1ps

module viterbi_decoder (
  input  logic                       clk,
  input  logic                       sys_rst,
  input  viterbi_pkg::soft_t         soft_i,
  input  logic                       soft_valid_i,
  output logic                       soft_ready_o,
  output viterbi_pkg::decision_vec_t decisions_o,
  output logic                       decision_valid_o,
  output viterbi_pkg::metric_t       state0_metric_o,
  output logic                       normalized_o
);
  import viterbi_pkg::*;

  soft_t          sym_i;
  soft_t          sym_q;
  logic           pair_valid;
  branch_metric_t metric_00;
  branch_metric_t metric_01;
  branch_metric_t metric_10;
  branch_metric_t metric_11;
  logic           metric_valid;

  symbol_pair_collector u_symbol_pair_collector (
    .clk          (clk),
    .sys_rst      (sys_rst),
    .soft_i       (soft_i),
    .soft_valid_i (soft_valid_i),
    .soft_ready_o (soft_ready_o),
    .sym_i_o      (sym_i),
    .sym_q_o      (sym_q),
    .pair_valid_o (pair_valid)
  );

  branch_metric_unit u_branch_metric_unit (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .sym_i_i        (sym_i),
    .sym_q_i        (sym_q),
    .pair_valid_i   (pair_valid),
    .metric_00_o    (metric_00),
    .metric_01_o    (metric_01),
    .metric_10_o    (metric_10),
    .metric_11_o    (metric_11),
    .metric_valid_o (metric_valid)
  );

  // decisions come out three edges after the Q sample
  trellis_array u_trellis_array (
    .clk              (clk),
    .sys_rst          (sys_rst),
    .metric_00_i      (metric_00),
    .metric_01_i      (metric_01),
    .metric_10_i      (metric_10),
    .metric_11_i      (metric_11),
    .metric_valid_i   (metric_valid),
    .decisions_o      (decisions_o),
    .decision_valid_o (decision_valid_o),
    .state0_metric_o  (state0_metric_o),
    .normalized_o     (normalized_o)
  );

endmodule

//--- hdl/viterbi_pkg.sv
package viterbi_pkg;

  // rate 1/2, K=7 code
  localparam int CONSTRAINT_LEN = 7;
  localparam int NUM_STATES = 2 ** (CONSTRAINT_LEN - 1);

  localparam logic [CONSTRAINT_LEN-1:0] POLY_G0 = 7'o171;
  localparam logic [CONSTRAINT_LEN-1:0] POLY_G1 = 7'o133;

  localparam int METRIC_W = 20;

  // offset binary, 255 is the strongest 1
  typedef logic [7:0] soft_t;
  typedef logic [8:0] branch_metric_t;
  typedef logic [METRIC_W-1:0] metric_t;
  typedef logic [CONSTRAINT_LEN-2:0] state_t;
  typedef logic [NUM_STATES-1:0] decision_vec_t;

  localparam soft_t SOFT_MAX = 8'd255;

  // half of the metric range
  localparam metric_t NORM_THRESHOLD = metric_t'(1) << (METRIC_W - 1);

  // encoder output for a state and input bit, bit 1 from G1 and bit 0 from G0
  function automatic logic [1:0] expected_code(state_t state, logic bit_in);
    logic [CONSTRAINT_LEN-1:0] word;
    word = {bit_in, state};
    return {^(word & POLY_G1), ^(word & POLY_G0)};
  endfunction

endpackage

//--- run_sim.sh
#!/bin/sh
# Builds the Viterbi front end testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=viterbi_decoder_sim

rm -rf obj_dir
if ! verilator --binary --timing --assert --top-module viterbi_decoder_tb \
    -f viterbi_decoder.f -o "$BIN"; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/"$BIN" > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error status"
  exit 1
fi
cat "$LOG"

if grep -q "Simulation completed successfully" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

//--- verification/viterbi_decoder_asserts.sv
`timescale 1ns/1ps

module viterbi_decoder_asserts (
  input logic clk,
  input logic sys_rst,
  input logic soft_ready_i,
  input logic decision_valid_i,
  input logic normalized_i
);

  // ready is registered, so it is low one edge into reset
  ready_low_in_reset: assert property (@(posedge clk) sys_rst |=> !soft_ready_i)
    else $error("soft_ready_o high while reset is applied");

  // pairs need two samples, so no back to back updates
  single_cycle_valid: assert property (
    @(posedge clk) disable iff (sys_rst) decision_valid_i |=> !decision_valid_i)
    else $error("decision_valid_o high on two cycles in a row");

  norm_with_valid: assert property (
    @(posedge clk) disable iff (sys_rst) normalized_i |-> decision_valid_i)
    else $error("normalized_o high without decision_valid_o");

endmodule

bind viterbi_decoder viterbi_decoder_asserts u_viterbi_decoder_asserts (
  .clk              (clk),
  .sys_rst          (sys_rst),
  .soft_ready_i     (soft_ready_o),
  .decision_valid_i (decision_valid_o),
  .normalized_i     (normalized_o)
);

//--- verification/viterbi_decoder_tb.sv
`timescale 1ns/1ps

module viterbi_decoder_tb;
  import viterbi_pkg::*;

  localparam logic [31:0] LCG_SEED = 32'h9908_d924;
  localparam int unsigned LATENCY = 3;
  localparam int TIMEOUT_CYCLES = 1000;

  typedef struct {
    decision_vec_t decisions;
    metric_t       metric0;
    logic          norm;
    int unsigned   q_cycle;
  } expect_t;

  logic          clk;
  logic          sys_rst;
  soft_t         soft_i;
  logic          soft_valid_i;
  logic          soft_ready_o;
  decision_vec_t decisions_o;
  logic          decision_valid_o;
  metric_t       state0_metric_o;
  logic          normalized_o;

  logic [31:0]   lcg_state;
  int unsigned   cycle_count;
  int unsigned   norm_events;
  metric_t       model_metric [NUM_STATES];
  expect_t       pending [$];

  viterbi_decoder u_viterbi_decoder (
    .clk              (clk),
    .sys_rst          (sys_rst),
    .soft_i           (soft_i),
    .soft_valid_i     (soft_valid_i),
    .soft_ready_o     (soft_ready_o),
    .decisions_o      (decisions_o),
    .decision_valid_o (decision_valid_o),
    .state0_metric_o  (state0_metric_o),
    .normalized_o     (normalized_o)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  function automatic logic [31:0] lcg_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic report_failure();
    $display("Simulation failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_decisions(input string name, input decision_vec_t got,
                                 input decision_vec_t exp);
    if (got !== exp) begin
      $display("error %s: expected 0x%h, got 0x%h", name, exp, got);
      report_failure();
    end
  endtask

  task automatic check_metric(input string name, input metric_t got, input metric_t exp);
    if (got !== exp) begin
      $display("error %s: expected 0x%h, got 0x%h", name, exp, got);
      report_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s: expected 0x%h, got 0x%h", name, exp, got);
      report_failure();
    end
  endtask

  // encoder taps walked one bit at a time
  function automatic logic [1:0] model_code(state_t s, logic b);
    logic [CONSTRAINT_LEN-1:0] word;
    logic [1:0]                code;
    word = {b, s};
    code = 2'b00;
    for (int k = 0; k < CONSTRAINT_LEN; k++) begin
      if (word[k]) begin
        code = code ^ {POLY_G1[k], POLY_G0[k]};
      end
    end
    return code;
  endfunction

  function automatic metric_t soft_dist(soft_t u, logic e);
    return e ? metric_t'(SOFT_MAX - u) : metric_t'(u);
  endfunction

  task automatic model_update(input soft_t sym_i, input soft_t sym_q);
    metric_t base [NUM_STATES];
    metric_t cand0;
    metric_t cand1;
    state_t  nxt;
    state_t  p0;
    logic [1:0] c0;
    logic [1:0] c1;
    expect_t exp;
    exp.norm = 1'b1;
    for (int s = 0; s < NUM_STATES; s++) begin
      if (model_metric[s] < NORM_THRESHOLD) begin
        exp.norm = 1'b0;
      end
    end
    for (int s = 0; s < NUM_STATES; s++) begin
      base[s] = exp.norm ? model_metric[s] - NORM_THRESHOLD : model_metric[s];
    end
    for (int n = 0; n < NUM_STATES; n++) begin
      nxt = state_t'(n);
      p0 = {nxt[4:0], 1'b0};
      c0 = model_code(p0, nxt[5]);
      c1 = model_code(p0 | state_t'(1), nxt[5]);
      cand0 = base[p0] + soft_dist(sym_i, c0[0]) + soft_dist(sym_q, c0[1]);
      cand1 = base[p0 | state_t'(1)] + soft_dist(sym_i, c1[0]) + soft_dist(sym_q, c1[1]);
      exp.decisions[n] = cand1 < cand0;
      model_metric[n] = (cand1 < cand0) ? cand1 : cand0;
    end
    exp.metric0 = model_metric[0];
    exp.q_cycle = cycle_count;
    if (exp.norm) begin
      norm_events++;
    end
    pending.push_back(exp);
  endtask

  // called on a falling edge, returns on the next one
  task automatic send_sample(input soft_t value);
    if (soft_ready_o !== 1'b1) begin
      $display("sample offered while soft_ready_o was not high");
      report_failure();
    end
    soft_i = value;
    soft_valid_i = 1'b1;
    @(negedge clk);
  endtask

  task automatic send_pair(input soft_t sym_i, input soft_t sym_q, input int gap);
    send_sample(sym_i);
    soft_valid_i = 1'b0;
    repeat (gap) @(negedge clk);
    model_update(sym_i, sym_q);
    send_sample(sym_q);
    soft_valid_i = 1'b0;
  endtask

  always @(negedge clk) begin
    if (!sys_rst && decision_valid_o) begin
      if (pending.size() == 0) begin
        $display("decision_valid_o rose with no symbol outstanding");
        report_failure();
      end else begin
        check_decisions("decisions_o", decisions_o, pending[0].decisions);
        check_metric("state0_metric_o", state0_metric_o, pending[0].metric0);
        check_flag("normalized_o", normalized_o, pending[0].norm);
        if (cycle_count - pending[0].q_cycle != LATENCY) begin
          $display("error decision_valid_o latency: expected 0x%h, got 0x%h",
                   LATENCY, cycle_count - pending[0].q_cycle);
          report_failure();
        end
        void'(pending.pop_front());
      end
    end
  end

  task automatic wait_for_decisions();
    int waited;
    waited = 0;
    while (pending.size() != 0 && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (pending.size() != 0) begin
      $display("timed out waiting for decision_valid_o");
      report_failure();
    end
  endtask

  task automatic apply_reset();
    sys_rst = 1'b1;
    soft_valid_i = 1'b0;
    repeat (5) @(negedge clk);
    sys_rst = 1'b0;
    for (int s = 0; s < NUM_STATES; s++) begin
      model_metric[s] = '0;
    end
    // ready is registered, so it comes up one edge after release
    @(negedge clk);
  endtask

  task automatic test_first_pair();
    check_flag("soft_ready_o", soft_ready_o, 1'b1);
    send_pair(8'h80, 8'h80, 0);
    wait_for_decisions();
  endtask

  task automatic test_strong_code();
    state_t      enc_state;
    logic [31:0] r;
    logic [1:0]  code;
    enc_state = '0;
    repeat (64) begin
      r = lcg_rand();
      code = expected_code(enc_state, r[31]);
      send_pair(code[0] ? SOFT_MAX : soft_t'(0), code[1] ? SOFT_MAX : soft_t'(0), 0);
      enc_state = {r[31], enc_state[5:1]};
    end
    wait_for_decisions();
  endtask

  task automatic test_random_stream(input logic with_gaps);
    logic [31:0] r;
    repeat (200) begin
      r = lcg_rand();
      send_pair(r[31:24], r[23:16], with_gaps ? int'(r[1:0]) + 1 : 0);
    end
    wait_for_decisions();
  endtask

  // 0x80 pairs add about 254 per update, half range after ~2060 updates
  task automatic test_normalization();
    int sent;
    norm_events = 0;
    sent = 0;
    while (norm_events < 2 && sent < 4500) begin
      send_pair(8'h80, 8'h80, 0);
      sent++;
    end
    wait_for_decisions();
    if (norm_events == 0) begin
      $display("metrics never reached the normalization threshold");
      report_failure();
    end
  endtask

  initial begin
    clk = 1'b0;
    sys_rst = 1'b1;
    soft_i = '0;
    soft_valid_i = 1'b0;
    cycle_count = 0;
    norm_events = 0;
    lcg_state = LCG_SEED;
    apply_reset();
    test_first_pair();
    test_strong_code();
    // same soft samples twice, with and without gaps
    apply_reset();
    lcg_state = LCG_SEED;
    test_random_stream(1'b0);
    apply_reset();
    lcg_state = LCG_SEED;
    test_random_stream(1'b1);
    test_normalization();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- viterbi_decoder.f
hdl/viterbi_pkg.sv
hdl/acs_unit.sv
hdl/metric_normalizer.sv
hdl/symbol_pair_collector.sv
hdl/branch_metric_unit.sv
hdl/trellis_array.sv
hdl/viterbi_decoder.sv
verification/viterbi_decoder_asserts.sv
verification/viterbi_decoder_tb.sv
